/* design/imu_pkg.sv */
// IMU poller shared definitions
// Accelerometer register map, SPI read flag and the structs passed
// between the sequencer, the SPI engine and the sample assembler
`default_nettype none

package imu_pkg;

  // Accelerometer output registers from the X high byte on
  localparam logic [7:0] accel_first_addr = 8'h3B;
  localparam logic [7:0] accel_last_addr  = 8'h40;

  // MSB of the address byte selects a read on the sensor
  localparam logic [7:0] spi_read_flag = 8'h80;

  // One finished register read from the SPI engine
  typedef struct packed {
    logic [6:0] addr;
    logic [7:0] data;
  } reg_read_t;

  // Two's complement axis value as the sensor reports it
  typedef logic signed [15:0] axis_t;

  // Full accelerometer sample with x in the upper bits
  typedef struct packed {
    axis_t x;
    axis_t y;
    axis_t z;
  } accel_sample_t;

endpackage

`default_nettype wire

/* design/imu_poller_top.sv */
// Accelerometer poller top level
// Sequencer, SPI register read engine and sample assembler in a chain
`timescale 1ns/100ps
`default_nettype none

module imu_poller_top #(
  parameter int clk_div       = 2,
  parameter int sample_period = 500
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   enable,
  input  logic                   miso,
  output logic                   sclk,
  output logic                   cs_n,
  output logic                   mosi,
  output imu_pkg::accel_sample_t sample,
  output logic                   sample_valid
);

  import imu_pkg::*;

  logic       req_start;
  logic [6:0] req_addr;
  logic       busy;
  logic       rd_done;
  reg_read_t  rd_result;

  imu_read_sequencer #(
    .sample_period(sample_period)
  ) seq_i (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .busy     (busy),
    .req_start(req_start),
    .req_addr (req_addr)
  );

  spi_reg_read #(
    .clk_div(clk_div)
  ) spi_i (
    .clk      (clk),
    .rst      (rst),
    .req_start(req_start),
    .req_addr (req_addr),
    .miso     (miso),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .busy     (busy),
    .rd_done  (rd_done),
    .rd_result(rd_result)
  );

  sample_assembler asm_i (
    .clk         (clk),
    .rst         (rst),
    .rd_done     (rd_done),
    .rd_result   (rd_result),
    .sample      (sample),
    .sample_valid(sample_valid)
  );

endmodule

`default_nettype wire

/* design/imu_read_sequencer.sv */
// Accelerometer burst sequencer
// A period timer starts one burst of six register reads; each read is
// launched after the SPI engine drops busy from the previous one
`timescale 1ns/100ps
`default_nettype none

module imu_read_sequencer #(
  parameter int sample_period = 500
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       enable,
  input  logic       busy,
  output logic       req_start,
  output logic [6:0] req_addr
);

  import imu_pkg::*;

  localparam int cnt_w = (sample_period > 1) ? $clog2(sample_period) : 1;

  logic [cnt_w-1:0] period_cnt;
  logic             tick;
  logic             active;
  logic             busy_q;
  logic             busy_fell;
  logic             burst_launch;
  logic             step_start;
  logic [6:0]       addr_q;

  // Free-running period timer
  assign tick = (period_cnt == cnt_w'(sample_period - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      period_cnt <= '0;
    end else if (tick) begin
      period_cnt <= '0;
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  // A tick during a running burst is dropped
  assign burst_launch = tick & enable & ~active & ~busy;

  assign busy_fell = busy_q & ~busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q     <= 1'b0;
      active     <= 1'b0;
      step_start <= 1'b0;
      addr_q     <= accel_first_addr[6:0];
    end else begin
      busy_q     <= busy;
      step_start <= 1'b0;
      if (burst_launch) begin
        active <= 1'b1;
      end else if (active && busy_fell) begin
        if (addr_q == accel_last_addr[6:0]) begin
          // Park on the first register once the burst is complete
          active <= 1'b0;
          addr_q <= accel_first_addr[6:0];
        end else begin
          addr_q     <= addr_q + 7'd1;
          step_start <= 1'b1;
        end
      end
    end
  end

  // First read of a burst goes out in the tick cycle itself,
  // later reads one cycle after busy falls
  assign req_start = burst_launch | step_start;
  assign req_addr  = addr_q;

endmodule

`default_nettype wire

/* design/sample_assembler.sv */
// Accelerometer sample assembler
// Places each returned byte in a staging sample by register address and
// publishes the three axes once the last register has arrived
`timescale 1ns/100ps
`default_nettype none

module sample_assembler (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rd_done,
  input  imu_pkg::reg_read_t     rd_result,
  output imu_pkg::accel_sample_t sample,
  output logic                   sample_valid
);

  import imu_pkg::*;

  accel_sample_t stage_q;
  accel_sample_t stage_next;
  accel_sample_t sample_q;
  logic          valid_q;
  logic          in_range;
  logic          last_byte;
  logic [6:0]    offset;

  assign in_range  = (rd_result.addr >= accel_first_addr[6:0]) &&
                     (rd_result.addr <= accel_last_addr[6:0]);
  assign offset    = rd_result.addr - accel_first_addr[6:0];
  assign last_byte = rd_done && (rd_result.addr == accel_last_addr[6:0]);

  // Offset 0 is x high byte, offset 5 is z low byte
  always_comb begin
    int lsb;
    lsb        = 8 * (5 - int'(offset[2:0]));
    stage_next = stage_q;
    if (rd_done && in_range) begin
      stage_next[lsb +: 8] = rd_result.data;
    end
  end

  always_ff @(posedge clk) begin
    stage_q <= stage_next;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sample_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= last_byte;
      if (last_byte) begin
        sample_q <= stage_next;
      end
    end
  end

  assign sample       = sample_q;
  assign sample_valid = valid_q;

endmodule

`default_nettype wire

/* design/spi_reg_read.sv */
// SPI mode-3 single register read
// Sends the address byte with the read flag set, MSB first, then clocks
// in one data byte; cs_n frames the whole transfer
`timescale 1ns/100ps
`default_nettype none

module spi_reg_read #(
  parameter int clk_div = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_start,
  input  logic [6:0]         req_addr,
  input  logic               miso,
  output logic               sclk,
  output logic               cs_n,
  output logic               mosi,
  output logic               busy,
  output logic               rd_done,
  output imu_pkg::reg_read_t rd_result
);

  import imu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_lead,
    st_addr,
    st_data
  } state_t;

  localparam int half_w = $clog2(clk_div);

  state_t            state_q, state_d;
  logic [half_w-1:0] half_q, half_d;
  logic [2:0]        bit_q, bit_d;
  logic              sclk_q, sclk_d;
  logic              cs_n_q, cs_n_d;
  logic              mosi_q, mosi_d;
  logic              rd_done_q, rd_done_d;
  logic [7:0]        tx_q, tx_d;
  logic [7:0]        rx_q, rx_d;
  logic [6:0]        addr_q, addr_d;
  reg_read_t         result_q, result_d;
  logic              half_end;

  // Last cycle of an SCLK half-period
  assign half_end = (half_q == half_w'(clk_div - 1));

  always_comb begin
    state_d   = state_q;
    half_d    = half_end ? '0 : half_q + 1'b1;
    bit_d     = bit_q;
    sclk_d    = sclk_q;
    cs_n_d    = cs_n_q;
    mosi_d    = mosi_q;
    rd_done_d = 1'b0;
    tx_d      = tx_q;
    rx_d      = rx_q;
    addr_d    = addr_q;
    result_d  = result_q;

    case (state_q)
      st_idle: begin
        half_d = '0;
        bit_d  = '0;
        if (req_start) begin
          state_d = st_lead;
          cs_n_d  = 1'b0;
          tx_d    = spi_read_flag | {1'b0, req_addr};
          addr_d  = req_addr;
        end
      end

      // SCLK stays high for one half-period after cs_n falls
      st_lead: begin
        if (half_end) begin
          state_d = st_addr;
          sclk_d  = 1'b0;
          mosi_d  = tx_q[7];
          tx_d    = {tx_q[6:0], 1'b0};
        end
      end

      st_addr: begin
        if (half_end) begin
          if (!sclk_q) begin
            sclk_d = 1'b1;
          end else begin
            sclk_d = 1'b0;
            bit_d  = bit_q + 3'd1;
            if (bit_q == 3'd7) begin
              state_d = st_data;
              mosi_d  = 1'b0;
            end else begin
              mosi_d = tx_q[7];
              tx_d   = {tx_q[6:0], 1'b0};
            end
          end
        end
      end

      st_data: begin
        if (half_end) begin
          if (!sclk_q) begin
            // Sample miso on the rising edge
            sclk_d = 1'b1;
            rx_d   = {rx_q[6:0], miso};
          end else if (bit_q == 3'd7) begin
            state_d   = st_idle;
            cs_n_d    = 1'b1;
            rd_done_d = 1'b1;
            result_d  = '{addr: addr_q, data: rx_q};
          end else begin
            sclk_d = 1'b0;
            bit_d  = bit_q + 3'd1;
          end
        end
      end

      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= st_idle;
      half_q    <= '0;
      bit_q     <= '0;
      sclk_q    <= 1'b1;
      cs_n_q    <= 1'b1;
      mosi_q    <= 1'b0;
      rd_done_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      half_q    <= half_d;
      bit_q     <= bit_d;
      sclk_q    <= sclk_d;
      cs_n_q    <= cs_n_d;
      mosi_q    <= mosi_d;
      rd_done_q <= rd_done_d;
    end
  end

  // Shift and result registers
  always_ff @(posedge clk) begin
    tx_q     <= tx_d;
    rx_q     <= rx_d;
    addr_q   <= addr_d;
    result_q <= result_d;
  end

  assign sclk      = sclk_q;
  assign cs_n      = cs_n_q;
  assign mosi      = mosi_q;
  assign busy      = (state_q != st_idle);
  assign rd_done   = rd_done_q;
  assign rd_result = result_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the IMU poller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --top-module imu_poller_tb -f vlog.f \
  -o sim_imu_poller > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_imu_poller +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "Simulation passed" sim.log && exit 0 || exit 1

/* tb/imu_poller_sva.sv */
// Protocol assertions for the IMU poller
// Bound into the top level to watch SPI framing and the sample strobe
`timescale 1ns/100ps
`default_nettype none

module imu_poller_sva (
  input logic clk,
  input logic rst,
  input logic busy,
  input logic cs_n,
  input logic sclk,
  input logic sample_valid
);

  int fail_count = 0;

  // Chip select frames the whole register read
  cs_low_in_transfer: assert property (@(posedge clk) disable iff (rst) busy |-> !cs_n)
    else begin
      $error("cs_n went high while a register read was in progress");
      fail_count = fail_count + 1;
    end

  // Mode 3 idle level
  sclk_high_when_idle: assert property (@(posedge clk) disable iff (rst) cs_n |-> sclk)
    else begin
      $error("sclk low while cs_n is high");
      fail_count = fail_count + 1;
    end

  valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
    sample_valid |=> !sample_valid)
    else begin
      $error("sample_valid held for more than one cycle");
      fail_count = fail_count + 1;
    end

endmodule

bind imu_poller_top imu_poller_sva sva_i (
  .clk         (clk),
  .rst         (rst),
  .busy        (busy),
  .cs_n        (cs_n),
  .sclk        (sclk),
  .sample_valid(sample_valid)
);

`default_nettype wire

/* tb/imu_poller_tb.sv */
// IMU poller testbench
// Random register contents in an SPI slave model, samples compared with
// a reference assembly of the same registers, bus activity checked
`timescale 1ns/100ps
`default_nettype none

module imu_poller_tb;

  import imu_pkg::*;

  localparam int clk_div       = 2;
  localparam int sample_period = 500;
  localparam int n_samples     = 20;
  localparam int n_window      = 10;
  // Idle test, one test per sample, window test, enable-off test
  localparam int n_tests       = 3 + n_samples;
  localparam int cycle_limit   = n_tests * 4 * sample_period;

  logic          clk, rst, enable, miso, sclk, cs_n, mosi, sample_valid;
  accel_sample_t sample;
  logic [7:0]    ref_regs [0:127];
  int            seed       = 25018;
  int            errors     = 0;
  int            tests_run  = 0;
  int            cycles     = 0;
  int            log_base   = 0;
  int            mosi_base  = 0;

  tb_clock_gen #(.period_ns(20), .reset_cycles(8)) clk_gen_i (.clk(clk), .rst(rst));

  imu_poller_top #(.clk_div(clk_div), .sample_period(sample_period)) dut_i (
    .clk(clk), .rst(rst), .enable(enable), .miso(miso), .sclk(sclk), .cs_n(cs_n),
    .mosi(mosi), .sample(sample), .sample_valid(sample_valid)
  );

  mpu_spi_model model_i (.sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso));

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic expect_equal(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
    assert (got == exp) else begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic load_random_regs();
    logic [7:0] val;
    for (int a = 0; a < 128; a++) begin
      val = 8'($random(seed));
      ref_regs[7'(a)] = val;
      model_i.regs[7'(a)] = val;
    end
  endtask

  // High byte at 0x3B + 2k, low byte right after it
  function automatic logic [15:0] expected_axis(input int k);
    return {ref_regs[7'(8'h3B + 2 * k)], ref_regs[7'(8'h3C + 2 * k)]};
  endfunction

  task automatic wait_sample();
    do @(negedge clk); while (!sample_valid);
  endtask

  task automatic watch_idle(input int n_cycles);
    for (int i = 0; i < n_cycles; i++) begin
      @(negedge clk);
      assert (cs_n && sclk && !sample_valid) else begin
        $display("Bus activity or a sample while enable was low, cycle %0d", cycles);
        errors++;
      end
    end
  endtask

  task automatic check_sample();
    expect_equal("sample.x", sample.x, expected_axis(0));
    expect_equal("sample.y", sample.y, expected_axis(1));
    expect_equal("sample.z", sample.z, expected_axis(2));
    assert (model_i.addr_count == log_base + 6) else begin
      $display("Burst sent %0d address bytes instead of 6", model_i.addr_count - log_base);
      errors++;
    end
    for (int k = 0; k < 6; k++) begin
      expect_equal($sformatf("addr_byte[%0d]", k), {8'h00, model_i.addr_log[10'(log_base + k)]},
                   16'(16'h00BB + k));
    end
    assert (model_i.mosi_errors == mosi_base) else begin
      $display("mosi was high during a data byte");
      errors++;
    end
    log_base  = model_i.addr_count;
    mosi_base = model_i.mosi_errors;
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  initial begin
    int err_before;
    int last_pulse;
    enable = 1'b0;
    load_random_regs();
    while (rst !== 1'b0) @(negedge clk);

    err_before = errors;
    watch_idle(2000);
    expect_equal("sample.x", sample.x, 16'h0000);
    expect_equal("sample.y", sample.y, 16'h0000);
    expect_equal("sample.z", sample.z, 16'h0000);
    report_test("idle with enable low", err_before);

    // New register contents after each sample and before the next tick
    log_base  = model_i.addr_count;
    mosi_base = model_i.mosi_errors;
    enable    = 1'b1;
    for (int s = 0; s < n_samples; s++) begin
      err_before = errors;
      wait_sample();
      check_sample();
      report_test($sformatf("random sample %0d", s), err_before);
      load_random_regs();
    end

    err_before = errors;
    last_pulse = cycles;
    for (int p = 0; p < n_window; p++) begin
      wait_sample();
      check_sample();
      assert (cycles - last_pulse == sample_period) else begin
        $display("Sample came %0d cycles after the previous one", cycles - last_pulse);
        errors++;
      end
      last_pulse = cycles;
    end
    report_test("one sample per period", err_before);

    // Drop enable in the middle of a burst, which still completes
    err_before = errors;
    while (cs_n) @(negedge clk);
    enable = 1'b0;
    wait_sample();
    check_sample();
    watch_idle(3 * sample_period);
    report_test("enable low stops bursts", err_before);

    errors = errors + dut_i.sva_i.fail_count;
    $display("Tests %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/mpu_spi_model.sv */
// Behavioral SPI mode-3 slave for the accelerometer registers
// Captures the address byte, returns one byte from a 128-entry register
// file and logs every address byte it receives
`timescale 1ns/100ps
`default_nettype none

module mpu_spi_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  logic [7:0] regs [0:127];
  logic [7:0] addr_log [0:1023];
  int         addr_count  = 0;
  int         mosi_errors = 0;
  int         bit_cnt     = 0;
  logic [7:0] rx_byte     = 8'h00;
  logic [7:0] cur_data    = 8'h00;
  logic       miso_q      = 1'b0;

  assign miso = miso_q;

  // Rising edges shift in the address bits and then check that mosi stays low
  always @(posedge sclk or posedge cs_n) begin
    if (cs_n) begin
      bit_cnt = 0;
    end else begin
      if (bit_cnt < 8) begin
        rx_byte = {rx_byte[6:0], mosi};
        if (bit_cnt == 7) begin
          addr_log[10'(addr_count)] = rx_byte;
          addr_count = addr_count + 1;
          cur_data = regs[rx_byte[6:0]];
        end
      end else if (mosi !== 1'b0) begin
        mosi_errors = mosi_errors + 1;
      end
      bit_cnt = bit_cnt + 1;
    end
  end

  // Falling edges after the address byte shift data out MSB first
  always @(negedge sclk) begin
    if (!cs_n && bit_cnt >= 8 && bit_cnt < 16) begin
      miso_q = cur_data[3'(15 - bit_cnt)];
    end
  end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Testbench clock and reset source
// Free-running clock and a reset held for a fixed number of cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Reset drops on a falling edge, away from the DUT sampling edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* vlog.f */
design/imu_pkg.sv
design/imu_read_sequencer.sv
design/spi_reg_read.sv
design/sample_assembler.sv
design/imu_poller_top.sv
tb/tb_clock_gen.sv
tb/mpu_spi_model.sv
tb/imu_poller_sva.sv
tb/imu_poller_tb.sv
